// ==== boot.hex ====
// one 32-bit boot word per line, word index 0 upward, unlisted words read as zero
b007005a
b007015b
b0070258
b0070359
b007045e
b007055f
b007065c
b007075d
b0070852
b0070953
b0070a50
b0070b51
b0070c56
b0070d57
b0070e54

// ==== design/pe_boot_rom.sv ====
module pe_boot_rom
  import pe_map_pkg::*;
(
  input  logic     clock,
  input  logic     en_i,
  input  rom_idx_t idx_i,
  output word_t    rdata_o
);

  word_t mem [BOOT_WORDS];

  // words not covered by the image read as zero
  initial begin
    for (int i = 0; i < BOOT_WORDS; i++) begin
      mem[i] = '0;
    end
    $readmemh(BOOT_FILE, mem);
  end

  always_ff @(posedge clock) begin
    if (en_i) begin
      rdata_o <= mem[idx_i];  // registered read
    end
  end

endmodule

// ==== design/pe_bus_decoder.sv ====
module pe_bus_decoder
  import pe_map_pkg::*;
(
  input  logic     clock,
  input  logic     rst_n_i,
  input  bus_req_t bus_req_i,
  output rom_idx_t rom_idx_o,
  output logic     rom_en_o,
  output ram_idx_t ram_idx_o,
  output logic     ram_we_o,
  output word_t    ram_wdata_o,
  output logic     per_sel_o,
  output logic     per_wr_o,
  output per_off_t per_off_o,
  output word_t    per_wdata_o,
  output logic     dma_sel_o,
  output logic     dma_wr_o,
  input  word_t    rom_rdata_i,
  input  word_t    ram_rdata_i,
  input  word_t    per_rdata_i,
  input  word_t    dma_status_i,
  output word_t    rdata_o,
  output logic     illegal_o
);

  addr_t addr;
  logic  hit_rom, hit_ram, hit_per, hit_dma, hit_any;
  logic  rd_rom_q, rd_ram_q, rd_per_q, rd_dma_q; // region of the previous read
  logic  illegal_q;
  word_t dma_status_q;

  // ==================================================
  // region decode
  // ==================================================
  assign addr    = bus_req_i.addr;
  assign hit_rom = bus_req_i.en && addr >= BOOT_START && addr <= BOOT_END;
  assign hit_ram = bus_req_i.en && addr >= RAM_START && addr <= RAM_END;
  assign hit_per = bus_req_i.en && addr >= PERIPH_START && addr <= PERIPH_END;
  assign hit_dma = bus_req_i.en && addr >= INTERNAL_START && addr <= INTERNAL_END;
  assign hit_any = hit_rom || hit_ram || hit_per || hit_dma;

  // word aligned, masked to each region
  assign rom_idx_o   = addr[2 +: $bits(rom_idx_t)];
  assign rom_en_o    = hit_rom && !bus_req_i.we;  // writes to rom are dropped
  assign ram_idx_o   = addr[2 +: $bits(ram_idx_t)];
  assign ram_we_o    = hit_ram && bus_req_i.we;
  assign ram_wdata_o = bus_req_i.wdata;
  assign per_sel_o   = hit_per;
  assign per_wr_o    = hit_per && bus_req_i.we;
  assign per_off_o   = {addr[3:2], 2'b00};
  assign per_wdata_o = bus_req_i.wdata;
  assign dma_sel_o   = hit_dma;
  assign dma_wr_o    = hit_dma && bus_req_i.we;

  // ==================================================
  // read return, one cycle later
  // ==================================================
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_rom_q  <= 1'b0;
      rd_ram_q  <= 1'b0;
      rd_per_q  <= 1'b0;
      rd_dma_q  <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      rd_rom_q  <= hit_rom && !bus_req_i.we;
      rd_ram_q  <= hit_ram && !bus_req_i.we;
      rd_per_q  <= hit_per && !bus_req_i.we;
      rd_dma_q  <= hit_dma && !bus_req_i.we;
      illegal_q <= bus_req_i.en && !hit_any; // one-cycle pulse
    end
  end

  // dma status is combinational at the source
  always_ff @(posedge clock) begin
    if (hit_dma) dma_status_q <= dma_status_i;
  end

  always_comb begin
    rdata_o = '0;  // writes and unmapped reads return zero
    if (rd_rom_q)      rdata_o = rom_rdata_i;
    else if (rd_ram_q) rdata_o = ram_rdata_i;
    else if (rd_per_q) rdata_o = per_rdata_i;
    else if (rd_dma_q) rdata_o = dma_status_q;
  end

  assign illegal_o = illegal_q;

endmodule

// ==== design/pe_dual_port_ram.sv ====
module pe_dual_port_ram
  import pe_map_pkg::*;
(
  input  logic     clock,
  // ==================================================
  // port a, processor side
  // ==================================================
  input  ram_idx_t a_idx_i,
  input  logic     a_we_i,
  input  word_t    a_wdata_i,
  output word_t    a_rdata_o,
  // ==================================================
  // port b, dma side
  // ==================================================
  input  ram_idx_t b_idx_i,
  input  logic     b_we_i,
  input  word_t    b_wdata_i
);

  word_t mem [RAM_WORDS];

  always_ff @(posedge clock) begin
    if (a_we_i) begin
      mem[a_idx_i] <= a_wdata_i;
    end
    // later assignment, so port b wins a collision
    if (b_we_i) begin
      mem[b_idx_i] <= b_wdata_i;
    end
  end

  always_ff @(posedge clock) begin
    a_rdata_o <= mem[a_idx_i];  // old data on a same-cycle write
  end

endmodule

// ==== design/pe_flit_dma.sv ====
module pe_flit_dma
  import pe_map_pkg::*;
  import pe_noc_pkg::*;
(
  input  logic     clock,
  input  logic     rst_n_i,
  input  logic     flit_valid_i,
  input  flit_t    flit_i,
  output logic     credit_o,
  output ram_idx_t ram_idx_o,
  output logic     ram_we_o,
  output word_t    ram_wdata_o,
  input  logic     sel_i,
  input  logic     wr_i,
  output word_t    status_o,
  output logic     done_irq_o
);

  dma_state_e  state_q;
  dma_header_t hdr;
  ram_idx_t    idx_q;       // next ram word to write
  logic [15:0] rx_left_q;   // payload flits still expected
  logic [15:0] wr_cnt_q;    // payload flits written so far
  logic        wr_q;        // pending write, one cycle after arrival
  word_t       wdata_q;

  assign hdr = dma_header_t'(flit_i);

  // ==================================================
  // receiver fsm
  // ==================================================
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      idx_q     <= '0;
      rx_left_q <= '0;
      wr_cnt_q  <= '0;
      wr_q      <= 1'b0;
    end else begin
      wr_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (flit_valid_i) begin
            idx_q     <= hdr.word_addr[$bits(ram_idx_t)-1:0]; // wraps at RAM_WORDS
            rx_left_q <= hdr.length;
            wr_cnt_q  <= '0;
            state_q   <= (hdr.length == '0) ? DONE : WRITE;
          end
        end
        WRITE: begin
          if (flit_valid_i && rx_left_q != '0) begin
            wr_q      <= 1'b1;
            rx_left_q <= rx_left_q - 1'b1;
          end
          if (wr_q) begin
            idx_q    <= idx_q + 1'b1;
            wr_cnt_q <= wr_cnt_q + 1'b1;
            if (rx_left_q == '0) state_q <= DONE; // last payload written
          end
        end
        DONE: begin
          if (sel_i && wr_i) state_q <= IDLE;     // any status write
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (flit_valid_i) wdata_q <= flit_i;
  end

  // credit only while a flit can still be taken
  assign credit_o    = (state_q == IDLE) || (state_q == WRITE && rx_left_q != '0);
  assign ram_idx_o   = idx_q;
  assign ram_we_o    = wr_q;
  assign ram_wdata_o = wdata_q;
  assign done_irq_o  = (state_q == DONE);

  always_comb begin
    status_o = '0;
    status_o[STATUS_DONE_BIT] = done_irq_o;
    status_o[STATUS_CNT_LSB +: 16] = wr_cnt_q;
  end

endmodule

// ==== design/pe_map_pkg.sv ====
package pe_map_pkg;

  // ==================================================
  // widths
  // ==================================================
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [7:0]  ram_idx_t;   // 256 words
  typedef logic [5:0]  rom_idx_t;   // 64 words
  typedef logic [3:0]  per_off_t;   // byte offset inside the register block
  typedef logic [1:0]  irq_t;       // bit 0 timer, bit 1 dma done

  typedef struct packed {
    logic  en;     // one cycle per access
    logic  we;
    addr_t addr;
    word_t wdata;
  } bus_req_t;

  // ==================================================
  // memory map
  // ==================================================
  localparam addr_t BOOT_START     = 32'h0000_0000;
  localparam addr_t BOOT_END       = 32'h1fff_ffff;
  localparam addr_t RAM_START      = 32'h4000_0000;
  localparam addr_t RAM_END        = 32'h5fff_ffff;
  localparam addr_t PERIPH_START   = 32'he100_0000;
  localparam addr_t PERIPH_END     = 32'hefff_ffff;
  localparam addr_t INTERNAL_START = 32'hf000_0000;
  localparam addr_t INTERNAL_END   = 32'hffff_ffff;

  localparam int    BOOT_WORDS = 64;
  localparam int    RAM_WORDS  = 256;
  localparam string BOOT_FILE  = "boot.hex";

  // peripheral registers
  localparam per_off_t REG_GPIO  = 4'h0;
  localparam per_off_t REG_CMP   = 4'h4;
  localparam per_off_t REG_COUNT = 4'h8;
  localparam per_off_t REG_IRQ   = 4'hC;

  localparam int IRQ_TIMER = 0;
  localparam int IRQ_DMA   = 1;

endpackage

// ==== design/pe_noc_pkg.sv ====
package pe_noc_pkg;

  // ==================================================
  // local port of the router
  // ==================================================
  typedef logic [31:0] flit_t;

  // first flit of every packet
  typedef struct packed {
    logic [15:0] length;     // payload flits that follow
    logic [15:0] word_addr;  // ram word index of the first payload flit
  } dma_header_t;

  // receiver fsm
  typedef enum logic [1:0] {
    IDLE  = 2'd0,  // waiting for a header
    WRITE = 2'd1,  // payload flits go to ram
    DONE  = 2'd2   // packet complete, credit held low
  } dma_state_e;

  localparam int STATUS_DONE_BIT = 0;
  localparam int STATUS_CNT_LSB  = 16;

endpackage

// ==== design/pe_peripherals.sv ====
module pe_peripherals
  import pe_map_pkg::*;
(
  input  logic     clock,
  input  logic     rst_n_i,
  input  logic     sel_i,
  input  logic     wr_i,
  input  per_off_t off_i,
  input  word_t    wdata_i,
  output word_t    rdata_o,
  output word_t    gpio_o,
  output logic     timer_irq_o
);

  word_t gpio_q;
  word_t cmp_q;
  word_t count_q;
  logic  irq_q;  // sticky until cleared

  // ==================================================
  // registers and compare timer
  // ==================================================
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_q  <= '0;
      cmp_q   <= '0;
      count_q <= '0;
      irq_q   <= 1'b0;
    end else begin
      if (sel_i && wr_i && off_i == REG_GPIO) gpio_q <= wdata_i;

      if (sel_i && wr_i && off_i == REG_CMP) begin
        cmp_q   <= wdata_i;
        count_q <= '0;  // new compare value restarts the count
      end else if (cmp_q == '0) begin
        count_q <= '0;  // timer stopped
      end else if (count_q == cmp_q) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end

      // write 1 clears, a match in the same cycle sets again
      if (sel_i && wr_i && off_i == REG_IRQ && wdata_i[0]) irq_q <= 1'b0;
      if (cmp_q != '0 && count_q == cmp_q) irq_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (sel_i && !wr_i) begin
      case (off_i)
        REG_GPIO:  rdata_o <= gpio_q;
        REG_CMP:   rdata_o <= cmp_q;
        REG_COUNT: rdata_o <= count_q;
        REG_IRQ:   rdata_o <= {31'b0, irq_q};
        default:   rdata_o <= '0;
      endcase
    end
  end

  assign gpio_o      = gpio_q;
  assign timer_irq_o = irq_q;

endmodule

// ==== design/pe_tile.sv ====
module pe_tile
  import pe_map_pkg::*;
  import pe_noc_pkg::*;
(
  input  logic     clock,
  input  logic     rst_n_i,
  input  bus_req_t bus_req_i,
  output word_t    rdata_o,
  output logic     illegal_o,
  input  logic     flit_valid_i,
  input  flit_t    flit_i,
  output logic     credit_o,
  output irq_t     irq_o,
  output word_t    gpio_o
);

  rom_idx_t rom_idx;
  logic     rom_en;
  word_t    rom_rdata;
  ram_idx_t ram_a_idx, ram_b_idx;
  logic     ram_a_we, ram_b_we;
  word_t    ram_a_wdata, ram_b_wdata, ram_a_rdata;
  logic     per_sel, per_wr;
  per_off_t per_off;
  word_t    per_wdata, per_rdata;
  logic     dma_sel, dma_wr;
  word_t    dma_status;

  // ==================================================
  // bus side
  // ==================================================
  pe_bus_decoder u_decoder (
    .clock, .rst_n_i, .bus_req_i,
    .rom_idx_o(rom_idx), .rom_en_o(rom_en),
    .ram_idx_o(ram_a_idx), .ram_we_o(ram_a_we), .ram_wdata_o(ram_a_wdata),
    .per_sel_o(per_sel), .per_wr_o(per_wr), .per_off_o(per_off), .per_wdata_o(per_wdata),
    .dma_sel_o(dma_sel), .dma_wr_o(dma_wr),
    .rom_rdata_i(rom_rdata), .ram_rdata_i(ram_a_rdata),
    .per_rdata_i(per_rdata), .dma_status_i(dma_status),
    .rdata_o, .illegal_o
  );

  pe_boot_rom u_rom (.clock, .en_i(rom_en), .idx_i(rom_idx), .rdata_o(rom_rdata));

  pe_dual_port_ram u_ram (
    .clock,
    .a_idx_i(ram_a_idx), .a_we_i(ram_a_we), .a_wdata_i(ram_a_wdata), .a_rdata_o(ram_a_rdata),
    .b_idx_i(ram_b_idx), .b_we_i(ram_b_we), .b_wdata_i(ram_b_wdata)
  );

  pe_peripherals u_periph (
    .clock, .rst_n_i, .sel_i(per_sel), .wr_i(per_wr), .off_i(per_off),
    .wdata_i(per_wdata), .rdata_o(per_rdata), .gpio_o, .timer_irq_o(irq_o[IRQ_TIMER])
  );

  // ==================================================
  // network side
  // ==================================================
  pe_flit_dma u_dma (
    .clock, .rst_n_i, .flit_valid_i, .flit_i, .credit_o,
    .ram_idx_o(ram_b_idx), .ram_we_o(ram_b_we), .ram_wdata_o(ram_b_wdata),
    .sel_i(dma_sel), .wr_i(dma_wr), .status_o(dma_status), .done_irq_o(irq_o[IRQ_DMA])
  );

endmodule

// ==== pe_tile.f ====
design/pe_map_pkg.sv
design/pe_noc_pkg.sv
design/pe_bus_decoder.sv
design/pe_boot_rom.sv
design/pe_dual_port_ram.sv
design/pe_peripherals.sv
design/pe_flit_dma.sv
design/pe_tile.sv
testbench/pe_tile_assertions.sv
testbench/pe_tile_tb.sv

// ==== testbench/pe_tile_assertions.sv ====
module pe_tile_assertions
  import pe_map_pkg::*;
  import pe_noc_pkg::*;
(
  input logic       clock,
  input logic       rst_n_i,
  input bus_req_t   bus_req_i,
  input logic [3:0] hit_i,       // rom, ram, periph, internal
  input logic       illegal_i,
  input dma_state_e state_i,
  input logic       ram_b_we_i,
  input logic       credit_i
);

  logic mapped;

  // periph and internal regions are contiguous up to the top of the map
  assign mapped = bus_req_i.addr <= BOOT_END || bus_req_i.addr >= PERIPH_START ||
                  (bus_req_i.addr >= RAM_START && bus_req_i.addr <= RAM_END);

  // ==================================================
  // decoder
  // ==================================================
  one_region: assert property (@(posedge clock) disable iff (!rst_n_i) $onehot0(hit_i))
    else $error("decoder selected more than one region");

  no_false_illegal: assert property (@(posedge clock) disable iff (!rst_n_i)
    bus_req_i.en && mapped |=> !illegal_i)
    else $error("illegal flag raised for a mapped address");

  // ==================================================
  // dma
  // ==================================================
  idle_no_write: assert property (@(posedge clock) disable iff (!rst_n_i)
    state_i == IDLE |-> !ram_b_we_i)
    else $error("dma wrote ram while idle");

  done_no_credit: assert property (@(posedge clock) disable iff (!rst_n_i)
    state_i == DONE |-> !credit_i)
    else $error("credit high while dma is done");

endmodule

bind pe_tile pe_tile_assertions u_checks (
  .clock,
  .rst_n_i,
  .bus_req_i,
  .hit_i({u_decoder.hit_rom, u_decoder.hit_ram, u_decoder.hit_per, u_decoder.hit_dma}),
  .illegal_i(illegal_o),
  .state_i(u_dma.state_q),
  .ram_b_we_i(ram_b_we),
  .credit_i(credit_o)
);

// ==== testbench/pe_tile_tb.sv ====
module pe_tile_tb
  import pe_map_pkg::*;
  import pe_noc_pkg::*;
();

  localparam int TIMEOUT = 200;  // cycles per wait

  logic     clock;
  logic     rst_n_i;
  bus_req_t bus_req;
  word_t    rdata;
  logic     illegal;
  logic     flit_valid;
  flit_t    flit;
  logic     credit;
  irq_t     irq;
  word_t    gpio;

  // reference models
  word_t rom_ref [BOOT_WORDS];
  word_t ram_ref [RAM_WORDS];
  word_t gpio_ref   = '0;
  word_t cmp_ref    = '0;
  word_t status_ref = '0;

  word_t seed      = 32'd81;
  int    checks    = 0;
  int    errors    = 0;
  int    errs_mark = 0;
  string test_name = "";

  pe_tile UUT (
    .clock, .rst_n_i, .bus_req_i(bus_req), .rdata_o(rdata), .illegal_o(illegal),
    .flit_valid_i(flit_valid), .flit_i(flit), .credit_o(credit), .irq_o(irq), .gpio_o(gpio)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // ==================================================
  // reference side
  // ==================================================
  function automatic word_t next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;  // lcg
    return seed;
  endfunction

  function automatic bit is_mapped(addr_t a);
    return a <= BOOT_END || (a >= RAM_START && a <= RAM_END) || a >= PERIPH_START;
  endfunction

  function automatic word_t expected_read(addr_t a);
    if (a <= BOOT_END) return rom_ref[a[7:2]];
    if (a >= RAM_START && a <= RAM_END) return ram_ref[a[9:2]];
    if (a >= INTERNAL_START) return status_ref;
    if (a >= PERIPH_START) begin
      // count and irq registers are not read over the bus here
      return (a[3:2] == 2'd0) ? gpio_ref : (a[3:2] == 2'd1) ? cmp_ref : '0;
    end
    return '0;  // unmapped
  endfunction

  function automatic void update_ref(bus_req_t r);
    if (r.addr >= RAM_START && r.addr <= RAM_END) begin
      ram_ref[r.addr[9:2]] = r.wdata;
    end else if (r.addr >= PERIPH_START && r.addr < INTERNAL_START) begin
      if (r.addr[3:2] == 2'd0) gpio_ref = r.wdata;
      if (r.addr[3:2] == 2'd1) cmp_ref = r.wdata;
    end
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s %s: expected %h, actual %h", test_name, name, exp, act);
    end
  endtask

  task automatic check_irq(input string name, input irq_t exp, input irq_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s %s: expected %b, actual %b", test_name, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input bit act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s %s: expected %b, actual %b", test_name, name, exp, act);
    end
  endtask

  // compare process, one cycle after each access
  initial begin
    bus_req_t req;
    word_t    exp;
    forever begin
      @(posedge clock);
      req = bus_req;  // value sampled by the dut at this edge
      if (rst_n_i && req.en) begin
        exp = req.we ? '0 : expected_read(req.addr);
        if (req.we) update_ref(req);
        @(negedge clock);
        if (rst_n_i) begin
          check_word($sformatf("rdata at %h", req.addr), exp, rdata);
          check_flag($sformatf("illegal at %h", req.addr), !is_mapped(req.addr), illegal);
        end
      end
    end
  end

  // ==================================================
  // stimulus helpers
  // ==================================================
  task automatic bus_access(input logic we, input addr_t a, input word_t d);
    @(posedge clock);
    bus_req <= '{en: 1'b1, we: we, addr: a, wdata: d};
  endtask

  task automatic release_bus();
    @(posedge clock);
    bus_req.en <= 1'b0;
  endtask

  task automatic send_flit(input flit_t f);
    int n;
    n = 0;
    do begin
      @(negedge clock);
      n++;
    end while (!credit && n < TIMEOUT);
    if (!credit) begin
      errors++;
      $display("no credit from the tile within %0d cycles, flit %h not sent", n, f);
    end else begin
      @(posedge clock);
      flit_valid <= 1'b1;
      flit       <= f;
      @(posedge clock);
      flit_valid <= 1'b0;
    end
  endtask

  task automatic wait_irq(input int bit_idx, output int cycles);
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!irq[bit_idx] && cycles < TIMEOUT);
    if (!irq[bit_idx]) begin
      errors++;
      $display("irq bit %0d did not rise within %0d cycles", bit_idx, TIMEOUT);
    end
  endtask

  task automatic end_test();
    repeat (2) @(posedge clock);  // let the last compare finish
    if (errors == errs_mark) $display("test %-10s ok", test_name);
    else $display("test %-10s %0d errors", test_name, errors - errs_mark);
    errs_mark = errors;
  endtask

  // ==================================================
  // tests
  // ==================================================
  initial begin
    addr_t       a;
    word_t       d;
    int          cycles;
    int          len;
    dma_header_t hdr;

    rst_n_i    = 1'b0;
    bus_req    = '0;
    flit_valid = 1'b0;
    flit       = '0;
    foreach (rom_ref[i]) rom_ref[i] = '0;
    $readmemh(BOOT_FILE, rom_ref);
    repeat (16) @(posedge clock);
    rst_n_i <= 1'b1;

    test_name = "boot_rom";
    for (int i = 0; i < 24; i++) begin
      bus_access(1'b0, next_random() & BOOT_END, '0);
    end
    release_bus();
    end_test();

    // every word once through an aliased address, then mixed traffic
    test_name = "ram";
    for (int i = 0; i < RAM_WORDS; i++) begin
      a = RAM_START | (next_random() & 32'h1fff_fc00) | addr_t'(i << 2);
      bus_access(1'b1, a, next_random());
    end
    for (int i = 0; i < 200; i++) begin
      d = next_random();
      bus_access(d[31], RAM_START | (next_random() & 32'h1fff_ffff), d);
    end
    release_bus();
    end_test();

    test_name = "gpio_map";
    d = next_random();
    bus_access(1'b1, PERIPH_START | (next_random() & 32'h0eff_fff0) | REG_GPIO, d);
    bus_access(1'b0, PERIPH_START + 32'h40, '0);  // aliases REG_GPIO
    release_bus();
    @(negedge clock);
    check_word("gpio_o", d, gpio);
    for (int i = 0; i < 12; i++) begin
      d = next_random();
      case (i % 3)
        0:       a = {3'b001, d[28:0]};
        1:       a = {3'b011, d[28:0]};
        default: a = {4'b1000, d[27:0]};
      endcase
      bus_access(d[31], a, d);
    end
    release_bus();
    repeat (2) @(negedge clock);
    check_flag("illegal after pulse", 1'b0, illegal);
    end_test();

    test_name = "timer";
    d = 32'd4 + (next_random() & 32'h1f);
    bus_access(1'b1, PERIPH_START | REG_CMP, d);
    release_bus();
    wait_irq(IRQ_TIMER, cycles);
    // first counted negedge falls right after the edge that loads the compare
    check_word("timer latency", d + 1, word_t'(cycles - 1));
    bus_access(1'b1, PERIPH_START | REG_CMP, '0);  // stop the timer
    bus_access(1'b1, PERIPH_START | REG_IRQ, 32'h1);
    release_bus();
    @(negedge clock);
    check_irq("irq after clear", 2'b00, irq);
    end_test();

    test_name = "dma";
    len = 1 + int'(next_random() % 8);
    d = next_random();
    hdr.length    = 16'(len);
    hdr.word_addr = d[15:0];
    send_flit(flit_t'(hdr));
    for (int i = 0; i < len; i++) begin
      d = next_random();
      ram_ref[ram_idx_t'(hdr.word_addr + 16'(i))] = d;  // index wraps at 256 words
      send_flit(d);
    end
    wait_irq(IRQ_DMA, cycles);
    check_flag("credit in done", 1'b0, credit);
    status_ref = {16'(len), 15'b0, 1'b1};
    bus_access(1'b0, INTERNAL_START | 32'h10, '0);
    for (int i = 0; i < len; i++) begin
      a = RAM_START | {22'b0, ram_idx_t'(hdr.word_addr + 16'(i)), 2'b00};
      bus_access(1'b0, a, '0);
    end
    bus_access(1'b1, INTERNAL_START, '0);
    release_bus();
    @(negedge clock);
    check_flag("credit restored", 1'b1, credit);
    check_irq("irq after status write", 2'b00, irq);
    end_test();

    // timer, dma done and bus traffic all active when reset hits
    test_name = "reset";
    bus_access(1'b1, PERIPH_START, next_random() | 32'h1);
    bus_access(1'b1, PERIPH_START | REG_CMP, 32'd2);
    release_bus();
    send_flit('0);  // empty packet
    for (int i = 0; i < 8; i++) begin
      d = next_random();
      bus_access(d[31], RAM_START | (d & 32'h1fff_fffc), d);
    end
    @(negedge clock);
    check_irq("irq before reset", 2'b11, irq);
    @(posedge clock);
    rst_n_i <= 1'b0;
    @(negedge clock);
    check_word("rdata in reset", '0, rdata);
    check_flag("illegal in reset", 1'b0, illegal);
    check_flag("credit in reset", 1'b1, credit);
    check_irq("irq in reset", 2'b00, irq);
    check_word("gpio in reset", '0, gpio);
    gpio_ref = '0;
    cmp_ref  = '0;
    @(posedge clock);
    bus_req.en <= 1'b0;
    repeat (4) @(posedge clock);
    rst_n_i <= 1'b1;
    bus_access(1'b0, PERIPH_START, '0);
    release_bus();
    end_test();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
